/* flist.f */
logic/dma_pkg.sv
logic/dma_ctrl_fsm.sv
logic/dma_beat_counter.sv
logic/dma_obi_reader.sv
logic/dma_beat_buffer.sv
logic/dma_axi_writer.sv
logic/dma_backend.sv
test/tb_dma_mem_models.sv
test/tb_dma_backend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA backend testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_dma_backend \
    --Mdir obj_dir -o tb_dma_backend \
    -f flist.f

status=0
./obj_dir/tb_dma_backend > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit $status

/* test/tb_dma_backend.sv */
// DMA backend testbench
// Runs a table of copy requests against random bus stalls and checks
// the copied words, the burst format and the response flags

`default_nettype none

module tb_dma_backend import dma_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 6;
    localparam int WAIT_LIMIT = 5000;

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------

    addr_t     tbl_src   [NUM_ROWS] = '{32'h0000, 32'h0100, 32'h0800,
                                        32'h0000, 32'h0200, 32'h1c00};
    addr_t     tbl_dst   [NUM_ROWS] = '{32'h0000, 32'h0400, 32'h1000,
                                        32'h1800, 32'h1800, 32'h0800};
    tf_len_t   tbl_len   [NUM_ROWS] = '{11'd4, 11'd64, 11'd1024,
                                        11'd0, 11'd64, 11'd1024};
    // Write response the sink returns for the row
    axi_resp_t tbl_bresp [NUM_ROWS] = '{2'b00, 2'b00, 2'b00,
                                        2'b00, 2'b10, 2'b00};
    logic      tbl_err   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0,
                                        1'b1, 1'b1, 1'b0};

    logic      clk = 1'b0;
    logic      arst_n;
    addr_t     req_src_addr;
    addr_t     req_dst_addr;
    tf_len_t   req_length;
    logic      req_valid;
    logic      req_ready;
    logic      rsp_error;
    logic      rsp_valid;
    logic      rsp_ready;
    axi_resp_t bresp_sel;

    logic      obi_req;
    addr_t     obi_addr;
    logic      obi_gnt;
    logic      obi_rvalid;
    data_t     obi_rdata;
    addr_t     axi_awaddr;
    axi_len_t  axi_awlen;
    logic      axi_awvalid;
    logic      axi_awready;
    data_t     axi_wdata;
    logic      axi_wlast;
    logic      axi_wvalid;
    logic      axi_wready;
    logic      axi_bvalid;
    axi_resp_t axi_bresp;
    logic      axi_bready;
    logic      busy;

    int        fail_count = 0;
    int        rows_passed = 0;
    int        rows_failed = 0;
    bit        timed_out = 1'b0;

    always #2 clk = ~clk;

    dma_backend uut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_src_addr_i (req_src_addr),
        .req_dst_addr_i (req_dst_addr),
        .req_length_i   (req_length),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .rsp_error_o    (rsp_error),
        .rsp_valid_o    (rsp_valid),
        .rsp_ready_i    (rsp_ready),
        .obi_req_o      (obi_req),
        .obi_addr_o     (obi_addr),
        .obi_gnt_i      (obi_gnt),
        .obi_rvalid_i   (obi_rvalid),
        .obi_rdata_i    (obi_rdata),
        .axi_awaddr_o   (axi_awaddr),
        .axi_awlen_o    (axi_awlen),
        .axi_awvalid_o  (axi_awvalid),
        .axi_awready_i  (axi_awready),
        .axi_wdata_o    (axi_wdata),
        .axi_wlast_o    (axi_wlast),
        .axi_wvalid_o   (axi_wvalid),
        .axi_wready_i   (axi_wready),
        .axi_bvalid_i   (axi_bvalid),
        .axi_bresp_i    (axi_bresp),
        .axi_bready_o   (axi_bready),
        .busy_o         (busy)
    );

    tb_dma_mem_models i_mem (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .bresp_sel_i   (bresp_sel),
        .obi_req_i     (obi_req),
        .obi_addr_i    (obi_addr),
        .obi_gnt_o     (obi_gnt),
        .obi_rvalid_o  (obi_rvalid),
        .obi_rdata_o   (obi_rdata),
        .axi_awaddr_i  (axi_awaddr),
        .axi_awlen_i   (axi_awlen),
        .axi_awvalid_i (axi_awvalid),
        .axi_awready_o (axi_awready),
        .axi_wdata_i   (axi_wdata),
        .axi_wlast_i   (axi_wlast),
        .axi_wvalid_i  (axi_wvalid),
        .axi_wready_o  (axi_wready),
        .axi_bvalid_o  (axi_bvalid),
        .axi_bresp_o   (axi_bresp),
        .axi_bready_i  (axi_bready)
    );

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %08h, expected %08h", $time, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_len(input axi_len_t got, input axi_len_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d, expected %0d", $time, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %b, expected %b", $time, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAIL %0t: %s got %0d, expected %0d", $time, what, got, exp);
            fail_count++;
        end
    endtask

    // --------------------------------------------------
    // One table row, request to response handshake
    // --------------------------------------------------

    task automatic run_row(input int r);
        int          cnt;
        int          fails_at_start;
        int          beats;
        int          aw0;
        int          req0;
        int          w0;
        int          le0;
        logic [10:0] sidx;
        logic [10:0] didx;

        fails_at_start = fail_count;
        beats = int'(tbl_len[r]) / BYTES_PER_WORD;
        aw0   = i_mem.aw_count;
        req0  = i_mem.req_count;
        w0    = i_mem.w_count;
        le0   = i_mem.wlast_errs;

        @(posedge clk);
        bresp_sel    <= tbl_bresp[r];
        req_src_addr <= tbl_src[r];
        req_dst_addr <= tbl_dst[r];
        req_length   <= tbl_len[r];
        req_valid    <= 1'b1;

        // Ready seen at the falling edge, so the next rising edge accepts
        cnt = 0;
        @(negedge clk);
        while (!req_ready) begin
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("Timeout: request of row %0d was never accepted", r);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;

        // Wait for the response, ready must stay low meanwhile
        cnt = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            if (req_ready) begin
                $display("Row %0d: request ready rose while the transfer was open", r);
                fail_count++;
            end
            if (!busy) begin
                $display("Row %0d: busy dropped while the transfer was open", r);
                fail_count++;
            end
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("Timeout: no response for row %0d", r);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
        end
        if (tbl_len[r] == '0) begin
            check_count(cnt + 1, 1, "zero length response latency");
        end
        check_error(rsp_error, tbl_err[r], "response error flag");

        // Requester stalls, response must hold
        repeat (2) begin
            @(negedge clk);
            if (!rsp_valid || req_ready) begin
                $display("Row %0d: response dropped or request ready during a held response", r);
                fail_count++;
            end
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(posedge clk);
        rsp_ready <= 1'b0;

        // Back to idle once the response is taken
        @(negedge clk);
        if (busy || !req_ready) begin
            $display("Row %0d: not idle after the response handshake", r);
            fail_count++;
        end

        // Burst format
        check_count(i_mem.aw_count - aw0, (beats == 0) ? 0 : 1, "AW handshakes");
        check_count(i_mem.w_count - w0, beats, "W beats");
        check_count(i_mem.wlast_errs - le0, 0, "misplaced wlast");
        if (beats == 0) begin
            check_count(i_mem.req_count - req0, 0, "OBI request cycles");
        end else begin
            check_len(i_mem.last_awlen, axi_len_t'(beats - 1), "awlen");
        end

        // Destination word i mirrors source word i
        for (int i = 0; i < beats; i++) begin
            sidx = 11'((tbl_src[r] / BYTES_PER_WORD) + i);
            didx = 11'((tbl_dst[r] / BYTES_PER_WORD) + i);
            check_data(i_mem.dst_mem[didx], i_mem.src_mem[sidx],
                       $sformatf("row %0d word %0d", r, i));
        end

        if (fail_count == fails_at_start) begin
            rows_passed++;
            $display("Row %0d: length %0d bytes, passed", r, tbl_len[r]);
        end else begin
            rows_failed++;
            $display("Row %0d: length %0d bytes, %0d checks failed", r, tbl_len[r],
                     fail_count - fails_at_start);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        arst_n       = 1'b0;
        req_src_addr = '0;
        req_dst_addr = '0;
        req_length   = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        bresp_sel    = AXI_RESP_OKAY;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // Idle outputs straight after reset
        @(negedge clk);
        if (!req_ready || rsp_valid || obi_req || axi_awvalid || axi_wvalid || axi_bready
                || busy) begin
            $display("Outputs are not in their idle state after reset");
            fail_count++;
        end

        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
        end

        $display("Rows passed %0d, rows failed %0d, checks failed %0d",
                 rows_passed, rows_failed, fail_count);
        if (timed_out || fail_count != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_dma_mem_models.sv */
// Bus models for the DMA backend testbench
// OBI source memory with random grant and return delays, and an AXI
// write sink with random ready stalls that records bursts and words

`default_nettype none

module tb_dma_mem_models import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  axi_resp_t bresp_sel_i,
    // OBI source
    input  logic      obi_req_i,
    input  addr_t     obi_addr_i,
    output logic      obi_gnt_o,
    output logic      obi_rvalid_o,
    output data_t     obi_rdata_o,
    // AXI sink
    input  addr_t     axi_awaddr_i,
    input  axi_len_t  axi_awlen_i,
    input  logic      axi_awvalid_i,
    output logic      axi_awready_o,
    input  data_t     axi_wdata_i,
    input  logic      axi_wlast_i,
    input  logic      axi_wvalid_i,
    output logic      axi_wready_o,
    output logic      axi_bvalid_o,
    output axi_resp_t axi_bresp_o,
    input  logic      axi_bready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 2048;

    data_t       src_mem [MEM_WORDS];
    data_t       dst_mem [MEM_WORDS];
    integer      seed;
    bit          filled = 1'b0;

    // Reads granted but not yet returned, oldest first
    addr_t       rd_addr_q [$];
    addr_t       ret_addr;
    int          rd_delay;

    // Write side bookkeeping
    addr_t       aw_addr_q;
    int          wbeat;
    bit          b_owed;
    logic [10:0] widx;

    // Running totals read by the testbench
    int          req_count;
    int          grant_count;
    int          aw_count;
    int          w_count;
    int          wlast_errs;
    axi_len_t    last_awlen;

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Memories filled once, first time reset is seen
            if (!filled) begin
                seed = 15981;
                for (int i = 0; i < MEM_WORDS; i++) begin
                    src_mem[i] = $random(seed);
                    dst_mem[i] = data_t'(i) ^ 32'hd0d0_0000;
                end
                filled = 1'b1;
            end
            obi_gnt_o     <= 1'b0;
            obi_rvalid_o  <= 1'b0;
            obi_rdata_o   <= '0;
            axi_awready_o <= 1'b0;
            axi_wready_o  <= 1'b0;
            axi_bvalid_o  <= 1'b0;
            axi_bresp_o   <= AXI_RESP_OKAY;
            rd_addr_q.delete();
            rd_delay    = 0;
            aw_addr_q   = '0;
            wbeat       = 0;
            b_owed      = 1'b0;
            req_count   = 0;
            grant_count = 0;
            aw_count    = 0;
            w_count     = 0;
            wlast_errs  = 0;
            last_awlen  = '0;
        end else begin
            // --------------------------------------------------
            // Random ready stalls
            // --------------------------------------------------
            obi_gnt_o     <= ({$random(seed)} % 4) != 0;
            axi_awready_o <= ({$random(seed)} % 3) != 0;
            axi_wready_o  <= ({$random(seed)} % 4) != 0;

            // OBI address phase
            if (obi_req_i) begin
                req_count++;
            end
            if (obi_req_i && obi_gnt_o) begin
                grant_count++;
                rd_addr_q.push_back(obi_addr_i);
            end

            // In-order read returns after a random gap
            if (rd_delay > 0) begin
                rd_delay--;
                obi_rvalid_o <= 1'b0;
            end else if (rd_addr_q.size() != 0) begin
                ret_addr = rd_addr_q.pop_front();
                obi_rvalid_o <= 1'b1;
                obi_rdata_o  <= src_mem[ret_addr[12:2]];
                rd_delay = int'({$random(seed)} % 3);
            end else begin
                obi_rvalid_o <= 1'b0;
            end

            // --------------------------------------------------
            // AXI write sink
            // --------------------------------------------------
            if (axi_awvalid_i && axi_awready_o) begin
                aw_count++;
                aw_addr_q  = axi_awaddr_i;
                last_awlen = axi_awlen_i;
                wbeat      = 0;
            end
            if (axi_wvalid_i && axi_wready_o) begin
                widx = aw_addr_q[12:2] + 11'(wbeat);
                dst_mem[widx] = axi_wdata_i;
                // Last flag must mark exactly the final beat of the burst
                if (axi_wlast_i != (wbeat == int'(last_awlen))) begin
                    wlast_errs++;
                end
                if (axi_wlast_i) begin
                    b_owed = 1'b1;
                end
                wbeat++;
                w_count++;
            end
            // B held until the backend takes it
            if (axi_bvalid_o && axi_bready_i) begin
                axi_bvalid_o <= 1'b0;
            end else if (b_owed && !axi_bvalid_o && ({$random(seed)} % 2) != 0) begin
                axi_bvalid_o <= 1'b1;
                axi_bresp_o  <= bresp_sel_i;
                b_owed = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dma_backend.sv */
// DMA copy backend, top level
// Reads words over OBI and writes them as one AXI burst per request
// through a small beat buffer

`default_nettype none

module dma_backend import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // Request
    input  addr_t     req_src_addr_i,
    input  addr_t     req_dst_addr_i,
    input  tf_len_t   req_length_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    // Response
    output logic      rsp_error_o,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    // OBI read side
    output logic      obi_req_o,
    output addr_t     obi_addr_o,
    input  logic      obi_gnt_i,
    input  logic      obi_rvalid_i,
    input  data_t     obi_rdata_i,
    // AXI write side
    output addr_t     axi_awaddr_o,
    output axi_len_t  axi_awlen_o,
    output logic      axi_awvalid_o,
    input  logic      axi_awready_i,
    output data_t     axi_wdata_o,
    output logic      axi_wlast_o,
    output logic      axi_wvalid_o,
    input  logic      axi_wready_i,
    input  logic      axi_bvalid_i,
    input  axi_resp_t axi_bresp_i,
    output logic      axi_bready_o,
    output logic      busy_o
);

    // FSM control
    logic      cnt_load;
    beat_cnt_t cnt_beats;
    logic      aw_start;
    logic      aw_done;
    logic      b_done;
    axi_resp_t b_resp;

    // Counter status
    logic      read_pending;
    logic      last_beat;
    logic      write_done;

    // Datapath
    logic      read_issue;
    logic      write_beat;
    logic      push;
    data_t     push_data;
    logic      buf_pop;
    data_t     buf_data;
    logic      buf_empty;

    dma_ctrl_fsm i_ctrl_fsm (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_length_i (req_length_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_error_o  (rsp_error_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .cnt_load_o   (cnt_load),
        .cnt_beats_o  (cnt_beats),
        .aw_start_o   (aw_start),
        .aw_done_i    (aw_done),
        .write_done_i (write_done),
        .b_done_i     (b_done),
        .b_resp_i     (b_resp),
        .busy_o       (busy_o)
    );

    dma_beat_counter i_beat_counter (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .load_i         (cnt_load),
        .beats_i        (cnt_beats),
        .read_issue_i   (read_issue),
        .write_beat_i   (write_beat),
        .read_pending_o (read_pending),
        .last_beat_o    (last_beat),
        .write_done_o   (write_done)
    );

    dma_obi_reader i_obi_reader (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .load_i         (cnt_load),
        .src_addr_i     (req_src_addr_i),
        .read_pending_i (read_pending),
        .buf_pop_i      (buf_pop),
        .obi_req_o      (obi_req_o),
        .obi_addr_o     (obi_addr_o),
        .obi_gnt_i      (obi_gnt_i),
        .obi_rvalid_i   (obi_rvalid_i),
        .obi_rdata_i    (obi_rdata_i),
        .read_issue_o   (read_issue),
        .push_o         (push),
        .push_data_o    (push_data)
    );

    dma_beat_buffer i_beat_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (buf_pop),
        .pop_data_o  (buf_data),
        .empty_o     (buf_empty)
    );

    dma_axi_writer i_axi_writer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .aw_start_i    (aw_start),
        .dst_addr_i    (req_dst_addr_i),
        .beats_i       (cnt_beats),
        .last_beat_i   (last_beat),
        .buf_empty_i   (buf_empty),
        .buf_data_i    (buf_data),
        .buf_pop_o     (buf_pop),
        .write_beat_o  (write_beat),
        .aw_done_o     (aw_done),
        .b_done_o      (b_done),
        .b_resp_o      (b_resp),
        .axi_awaddr_o  (axi_awaddr_o),
        .axi_awlen_o   (axi_awlen_o),
        .axi_awvalid_o (axi_awvalid_o),
        .axi_awready_i (axi_awready_i),
        .axi_wdata_o   (axi_wdata_o),
        .axi_wlast_o   (axi_wlast_o),
        .axi_wvalid_o  (axi_wvalid_o),
        .axi_wready_i  (axi_wready_i),
        .axi_bvalid_i  (axi_bvalid_i),
        .axi_bresp_i   (axi_bresp_i),
        .axi_bready_o  (axi_bready_o)
    );

endmodule

`default_nettype wire

/* logic/dma_axi_writer.sv */
// AXI write channel driver
// One AW per transfer, W beats from the buffer head, then the B response

`default_nettype none

module dma_axi_writer import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      aw_start_i,
    input  addr_t     dst_addr_i,
    input  beat_cnt_t beats_i,
    input  logic      last_beat_i,
    input  logic      buf_empty_i,
    input  data_t     buf_data_i,
    output logic      buf_pop_o,
    output logic      write_beat_o,
    output logic      aw_done_o,
    output logic      b_done_o,
    output axi_resp_t b_resp_o,
    output addr_t     axi_awaddr_o,
    output axi_len_t  axi_awlen_o,
    output logic      axi_awvalid_o,
    input  logic      axi_awready_i,
    output data_t     axi_wdata_o,
    output logic      axi_wlast_o,
    output logic      axi_wvalid_o,
    input  logic      axi_wready_i,
    input  logic      axi_bvalid_i,
    input  axi_resp_t axi_bresp_i,
    output logic      axi_bready_o
);

    addr_t    awaddr_q;
    axi_len_t awlen_q;
    logic     awvalid_q;
    logic     w_open_q;
    logic     bready_q;
    logic     w_hs;

    // --------------------------------------------------
    // AW channel
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (aw_start_i) begin
            awaddr_q <= dst_addr_i;
            awlen_q  <= axi_len_t'(beats_i - beat_cnt_t'(1));
        end
    end

    assign aw_done_o = axi_awvalid_o & axi_awready_i;

    // --------------------------------------------------
    // W and B channels
    // --------------------------------------------------

    // Valid stays up since only a pop empties the buffer
    assign axi_wvalid_o = w_open_q & ~buf_empty_i;
    assign axi_wdata_o  = buf_data_i;
    assign axi_wlast_o  = axi_wvalid_o & last_beat_i;
    assign w_hs         = axi_wvalid_o & axi_wready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            awvalid_q <= 1'b0;
            w_open_q  <= 1'b0;
            bready_q  <= 1'b0;
        end else begin
            if (aw_start_i) begin
                awvalid_q <= 1'b1;
            end else if (aw_done_o) begin
                awvalid_q <= 1'b0;
            end
            // W window opens after the address phase
            if (aw_done_o) begin
                w_open_q <= 1'b1;
            end else if (w_hs && last_beat_i) begin
                w_open_q <= 1'b0;
            end
            if (w_hs && last_beat_i) begin
                bready_q <= 1'b1;
            end else if (b_done_o) begin
                bready_q <= 1'b0;
            end
        end
    end

    assign axi_awaddr_o  = awaddr_q;
    assign axi_awlen_o   = awlen_q;
    assign axi_awvalid_o = awvalid_q;
    assign axi_bready_o  = bready_q;

    assign buf_pop_o    = w_hs;
    assign write_beat_o = w_hs;
    assign b_done_o     = axi_bvalid_i & bready_q;
    assign b_resp_o     = axi_bresp_i;

endmodule

`default_nettype wire

/* logic/dma_beat_buffer.sv */
// Beat buffer
// Small FIFO between the OBI read returns and the AXI W channel

`default_nettype none

module dma_beat_buffer import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  push_i,
    input  data_t push_data_i,
    input  logic  pop_i,
    output data_t pop_data_o,
    output logic  empty_o
);

    data_t                          mem_q [BUF_DEPTH];
    logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr_q;
    buf_cnt_t                       count_q;
    logic                           full;

    assign empty_o    = (count_q == '0);
    assign full       = (count_q == buf_cnt_t'(BUF_DEPTH));
    assign pop_data_o = mem_q[rd_ptr_q];

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Reader credit keeps returns within capacity
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full
    );
    a_no_underflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) pop_i |-> !empty_o
    );

endmodule

`default_nettype wire

/* logic/dma_obi_reader.sv */
// OBI read issuer
// Requests source words under buffer credit and forwards returned data

`default_nettype none

module dma_obi_reader import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  load_i,
    input  addr_t src_addr_i,
    input  logic  read_pending_i,
    input  logic  buf_pop_i,
    output logic  obi_req_o,
    output addr_t obi_addr_o,
    input  logic  obi_gnt_i,
    input  logic  obi_rvalid_i,
    input  data_t obi_rdata_i,
    output logic  read_issue_o,
    output logic  push_o,
    output data_t push_data_o
);

    addr_t    addr_q;
    buf_cnt_t credit_q;
    logic     grant;

    // Reads in flight plus stored words never exceed the buffer
    assign obi_req_o  = read_pending_i & (credit_q < buf_cnt_t'(BUF_DEPTH));
    assign grant      = obi_req_o & obi_gnt_i;
    assign obi_addr_o = addr_q;

    // Address register, word stepping
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
        end else if (load_i) begin
            addr_q <= src_addr_i;
        end else if (grant) begin
            addr_q <= addr_q + addr_t'(BYTES_PER_WORD);
        end
    end

    // Credit taken on grant, returned when the writer pops
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= '0;
        end else begin
            case ({grant, buf_pop_i})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    assign read_issue_o = grant;
    // In-order returns go straight into the buffer
    assign push_o       = obi_rvalid_i;
    assign push_data_o  = obi_rdata_i;

endmodule

`default_nettype wire

/* logic/dma_beat_counter.sv */
// DMA beat counters
// Tracks read beats still to issue and write beats still to send

`default_nettype none

module dma_beat_counter import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      load_i,
    input  beat_cnt_t beats_i,
    input  logic      read_issue_i,
    input  logic      write_beat_i,
    output logic      read_pending_o,
    output logic      last_beat_o,
    output logic      write_done_o
);

    // Index 0 counts reads, index 1 counts writes
    beat_cnt_t  left_q [2];
    logic [1:0] dec;

    assign dec = {write_beat_i, read_issue_i};

    for (genvar i = 0; i < 2; i++) begin : gen_cnt
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                left_q[i] <= '0;
            end else if (load_i) begin
                left_q[i] <= beats_i;
            end else if (dec[i]) begin
                left_q[i] <= left_q[i] - 1'b1;
            end
        end

        // Grant or W handshake only while beats remain
        a_no_underflow: assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            dec[i] |-> (left_q[i] != '0)
        );
    end

    assign read_pending_o = (left_q[0] != '0);
    assign last_beat_o    = (left_q[1] == beat_cnt_t'(1));
    assign write_done_o   = (left_q[1] == '0);

endmodule

`default_nettype wire

/* logic/dma_ctrl_fsm.sv */
// DMA transfer control FSM
// Accepts requests, rejects zero lengths and produces the response

`default_nettype none

module dma_ctrl_fsm import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  tf_len_t   req_length_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    output logic      rsp_error_o,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output logic      cnt_load_o,
    output beat_cnt_t cnt_beats_o,
    output logic      aw_start_o,
    input  logic      aw_done_i,
    input  logic      write_done_i,
    input  logic      b_done_i,
    input  axi_resp_t b_resp_i,
    output logic      busy_o
);

    dma_state_e state_q;
    dma_state_e state_d;
    logic       accept;
    logic       len_zero;
    logic       error_q;

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i & req_ready_o;
    assign len_zero    = (req_length_i == '0);

    // Lengths are word multiples, so the shift is exact
    assign cnt_beats_o = beat_cnt_t'(req_length_i >> OFFSET_BITS);

    // Counter, reader and writer all start on the acceptance edge
    assign cnt_load_o  = accept & ~len_zero;
    assign aw_start_o  = accept & ~len_zero;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = len_zero ? RESP : AW;
                end
            end
            AW: begin
                if (aw_done_i) begin
                    state_d = RUN;
                end
            end
            // B may arrive the cycle after the last W beat, before WAIT_B
            RUN: begin
                if (b_done_i) begin
                    state_d = RESP;
                end else if (write_done_i) begin
                    state_d = WAIT_B;
                end
            end
            WAIT_B: begin
                if (b_done_i) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Error flag, zero length or a non-OKAY write response
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            error_q <= 1'b0;
        end else if (accept) begin
            error_q <= len_zero;
        end else if (b_done_i && (b_resp_i != AXI_RESP_OKAY)) begin
            error_q <= 1'b1;
        end
    end

    assign rsp_valid_o = (state_q == RESP);
    assign rsp_error_o = error_q;
    assign busy_o      = (state_q != IDLE);

    // Response held with stable error until the requester takes it
    a_rsp_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_error_o))
    );

endmodule

`default_nettype wire

/* logic/dma_pkg.sv */
// DMA backend package
// Shared widths, bus field types, the transfer FSM states
// and the beat buffer sizing

`default_nettype none

package dma_pkg;

    // --------------------------------------------------
    // Bus and transfer geometry
    // --------------------------------------------------

    // Bytes in one bus word
    localparam int unsigned BYTES_PER_WORD = 4;
    // Shift from a byte length to a word count
    localparam int unsigned OFFSET_BITS = $clog2(BYTES_PER_WORD);

    // Beat buffer entries, also the read credit limit
    localparam int unsigned BUF_DEPTH = 4;

    // OKAY code on the AXI B channel
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    // Length in bytes, up to one full burst of 1024
    typedef logic [10:0] tf_len_t;
    // Words per transfer, up to 256
    typedef logic [8:0]  beat_cnt_t;
    // AXI AxLEN, beats minus one
    typedef logic [7:0]  axi_len_t;
    typedef logic [1:0]  axi_resp_t;
    // Holds 0 to BUF_DEPTH inclusive
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] buf_cnt_t;

    // Transfer sequencing
    typedef enum logic [2:0] {
        IDLE,
        AW,
        RUN,
        WAIT_B,
        RESP
    } dma_state_e;

endpackage

`default_nettype wire
